//--- hw/eth_rx_pkg.sv
////////////////////
// Byte, color and Ethernet framing constants
// Shared 12-bit color word type
////////////////////
package eth_rx_pkg;

	// Byte and color widths
	localparam int BYTE_LEN = 8;
	localparam int COLOR_CHANNEL_LEN = 4;
	// Red, green and blue channels packed high to low
	localparam int COLOR_LEN = 3 * COLOR_CHANNEL_LEN;

	typedef logic [COLOR_LEN-1:0] color_t;

	// Ethernet preamble and start-of-frame delimiter
	localparam logic [BYTE_LEN-1:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [BYTE_LEN-1:0] SFD_BYTE = 8'hD5;
	// Longest preamble accepted before the delimiter
	localparam int MAX_PREAMBLE_LEN = 7;

	// Destination and source MAC addresses together
	localparam int ETH_MAC_HDR_LEN = 12;
	localparam int ETH_ETHERTYPE_LEN = 2;

	// Ethertype that marks an FGP frame, sent most significant byte first
	localparam logic [ETH_ETHERTYPE_LEN*BYTE_LEN-1:0] ETHERTYPE_FGP = 16'h8FF0;

endpackage

//--- hw/rmii_byte_assembler.sv
////////////////////
// RMII dibit to byte assembler
////////////////////
`timescale 1ns/1ps

module rmii_byte_assembler (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic crs_dv,
	input  logic [1:0] rxd,
	output logic byte_valid,
	output logic [eth_rx_pkg::BYTE_LEN-1:0] byte_data,
	output logic frame_end
);
	import eth_rx_pkg::*;

	// First three dibits of the byte being received
	logic [BYTE_LEN-3:0] partial_byte;
	logic [1:0] dibit_cnt;
	logic crs_dv_d;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			crs_dv_d <= 1'b0;
			dibit_cnt <= 2'd0;
			byte_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			crs_dv_d <= crs_dv;
			frame_end <= crs_dv_d && !crs_dv;
			byte_valid <= crs_dv && crs_dv_d && (dibit_cnt == 2'd3);
			if (crs_dv && crs_dv_d) begin
				dibit_cnt <= dibit_cnt + 2'd1;
			end else if (crs_dv) begin
				// Rising crs_dv carries dibit 0 of the first byte
				dibit_cnt <= 2'd1;
			end else begin
				dibit_cnt <= 2'd0;
			end
		end
	end

	// Least significant dibit arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (crs_dv) begin
			partial_byte <= {rxd, partial_byte[BYTE_LEN-3:2]};
			if (crs_dv_d && dibit_cnt == 2'd3) begin
				byte_data <= {rxd, partial_byte};
			end
		end
	end

endmodule

//--- hw/eth_frame_parser.sv
////////////////////
// Ethernet frame parser: preamble check,
// MAC header skip and ethertype filter
////////////////////
`timescale 1ns/1ps

module eth_frame_parser (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic byte_valid,
	input  logic [eth_rx_pkg::BYTE_LEN-1:0] byte_data,
	input  logic frame_end,
	output logic payload_valid,
	output logic [eth_rx_pkg::BYTE_LEN-1:0] payload_data,
	output logic payload_start,
	output logic frame_err
);
	import eth_rx_pkg::*;

	localparam logic [2:0] ST_PREAMBLE = 3'd0;
	localparam logic [2:0] ST_HEADER = 3'd1;
	localparam logic [2:0] ST_ETHERTYPE = 3'd2;
	localparam logic [2:0] ST_PAYLOAD = 3'd3;
	localparam logic [2:0] ST_DISCARD = 3'd4;

	logic [2:0] state;
	// Counts preamble, header or ethertype bytes depending on state
	logic [3:0] field_cnt;
	logic first_payload;
	// Ethertype byte that came first
	logic [BYTE_LEN-1:0] type_hi;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= ST_PREAMBLE;
			field_cnt <= 4'd0;
			first_payload <= 1'b0;
			payload_valid <= 1'b0;
			payload_start <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			payload_valid <= 1'b0;
			payload_start <= 1'b0;
			frame_err <= 1'b0;
			if (frame_end) begin
				state <= ST_PREAMBLE;
				field_cnt <= 4'd0;
				first_payload <= 1'b0;
			end else if (byte_valid) begin
				case (state)
					ST_PREAMBLE: begin
						if (byte_data == SFD_BYTE) begin
							state <= ST_HEADER;
							field_cnt <= 4'd0;
						end else if (byte_data == PREAMBLE_BYTE &&
								field_cnt < 4'(MAX_PREAMBLE_LEN)) begin
							field_cnt <= field_cnt + 4'd1;
						end else begin
							// Bad byte or preamble too long
							frame_err <= 1'b1;
							state <= ST_DISCARD;
						end
					end
					ST_HEADER: begin
						if (field_cnt == 4'(ETH_MAC_HDR_LEN - 1)) begin
							state <= ST_ETHERTYPE;
							field_cnt <= 4'd0;
						end else begin
							field_cnt <= field_cnt + 4'd1;
						end
					end
					ST_ETHERTYPE: begin
						if (field_cnt == 4'(ETH_ETHERTYPE_LEN - 1)) begin
							first_payload <= 1'b1;
							if ({type_hi, byte_data} == ETHERTYPE_FGP) begin
								state <= ST_PAYLOAD;
							end else begin
								state <= ST_DISCARD;
							end
						end else begin
							field_cnt <= field_cnt + 4'd1;
						end
					end
					ST_PAYLOAD: begin
						payload_valid <= 1'b1;
						payload_start <= first_payload;
						first_payload <= 1'b0;
					end
					default: begin
						// Discard until frame_end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid) begin
			type_hi <= byte_data;
			payload_data <= byte_data;
		end
	end

endmodule

//--- hw/fgp_rx.sv
////////////////////
// FGP packet splitter: offset byte and data block
////////////////////
`timescale 1ns/1ps

module fgp_rx #(
	parameter int FGP_DATA_LEN_COLORS = 64
) (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic payload_valid,
	input  logic [eth_rx_pkg::BYTE_LEN-1:0] payload_data,
	input  logic payload_start,
	input  logic frame_end,
	output logic offset_valid,
	output logic [eth_rx_pkg::BYTE_LEN-1:0] offset_data,
	output logic data_valid,
	output logic [eth_rx_pkg::BYTE_LEN-1:0] data_byte
);

	// Two colors take three bytes
	localparam int DATA_LEN_BYTES = FGP_DATA_LEN_COLORS * 3 / 2;
	localparam int CNT_W = $clog2(DATA_LEN_BYTES);

	logic [CNT_W-1:0] data_cnt;
	logic data_active;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
			data_active <= 1'b0;
			data_cnt <= '0;
		end else begin
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
			if (frame_end) begin
				data_active <= 1'b0;
			end else if (payload_valid && payload_start) begin
				// First payload byte is the offset
				offset_valid <= 1'b1;
				data_active <= 1'b1;
				data_cnt <= '0;
			end else if (payload_valid && data_active) begin
				data_valid <= 1'b1;
				if (data_cnt == CNT_W'(DATA_LEN_BYTES - 1)) begin
					// Block complete, anything after it is dropped
					data_active <= 1'b0;
				end else begin
					data_cnt <= data_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (payload_valid && payload_start) begin
			offset_data <= payload_data;
		end
		if (payload_valid) begin
			data_byte <= payload_data;
		end
	end

endmodule

//--- hw/bytes_to_colors.sv
////////////////////
// Byte to 12-bit color repacker
////////////////////
`timescale 1ns/1ps

module bytes_to_colors (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic data_valid,
	input  logic [eth_rx_pkg::BYTE_LEN-1:0] data_byte,
	input  logic frame_end,
	output logic color_valid,
	output eth_rx_pkg::color_t color
);
	import eth_rx_pkg::*;

	// Position of the next byte within its group of three
	logic [1:0] phase;
	// Previous byte of the group
	logic [BYTE_LEN-1:0] partial;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			phase <= 2'd0;
			color_valid <= 1'b0;
		end else begin
			color_valid <= 1'b0;
			if (frame_end) begin
				// A group cut short by the frame end is lost
				phase <= 2'd0;
			end else if (data_valid) begin
				color_valid <= (phase != 2'd0);
				if (phase == 2'd2) begin
					phase <= 2'd0;
				end else begin
					phase <= phase + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_valid) begin
			partial <= data_byte;
			if (phase == 2'd1) begin
				// Color A: byte 0 then upper nibble of byte 1
				color <= {partial, data_byte[BYTE_LEN-1 -: COLOR_CHANNEL_LEN]};
			end else if (phase == 2'd2) begin
				// Color B: lower nibble of byte 1 then byte 2
				color <= {partial[COLOR_CHANNEL_LEN-1:0], data_byte};
			end
		end
	end

endmodule

//--- hw/vram_stream_writer.sv
////////////////////
// Video RAM write port driver
////////////////////
`timescale 1ns/1ps

module vram_stream_writer #(
	parameter int FGP_DATA_LEN_COLORS = 64,
	parameter int VRAM_ADDR_WIDTH = 14
) (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic offset_valid,
	input  logic [eth_rx_pkg::BYTE_LEN-1:0] offset_data,
	input  logic color_valid,
	input  eth_rx_pkg::color_t color,
	output logic vram_we,
	output logic [VRAM_ADDR_WIDTH-1:0] vram_waddr,
	output eth_rx_pkg::color_t vram_wdata
);

	// Address of the next color to write
	logic [VRAM_ADDR_WIDTH-1:0] wr_addr;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			wr_addr <= '0;
			vram_we <= 1'b0;
		end else begin
			vram_we <= color_valid;
			if (offset_valid) begin
				// Packet k fills colors k*N .. k*N+N-1, wrapping at the RAM size
				wr_addr <= VRAM_ADDR_WIDTH'(int'(offset_data) * FGP_DATA_LEN_COLORS);
			end else if (color_valid) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (color_valid) begin
			vram_waddr <= wr_addr;
			vram_wdata <= color;
		end
	end

endmodule

//--- hw/eth_rx_vram_top.sv
////////////////////
// RMII receive to video RAM top level
////////////////////
`timescale 1ns/1ps

module eth_rx_vram_top #(
	parameter int FGP_DATA_LEN_COLORS = 64,
	parameter int VRAM_ADDR_WIDTH = 14
) (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic crs_dv,
	input  logic [1:0] rxd,
	output logic vram_we,
	output logic [VRAM_ADDR_WIDTH-1:0] vram_waddr,
	output eth_rx_pkg::color_t vram_wdata,
	output logic frame_err
);
	import eth_rx_pkg::*;

	logic byte_valid;
	logic [BYTE_LEN-1:0] byte_data;
	logic frame_end;

	logic payload_valid;
	logic [BYTE_LEN-1:0] payload_data;
	logic payload_start;

	logic offset_valid;
	logic [BYTE_LEN-1:0] offset_data;
	logic data_valid;
	logic [BYTE_LEN-1:0] data_byte;

	logic color_valid;
	color_t color;

	rmii_byte_assembler rmii_byte_assembler_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crs_dv(crs_dv),
		.rxd(rxd),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.frame_end(frame_end)
	);

	eth_frame_parser eth_frame_parser_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.frame_end(frame_end),
		.payload_valid(payload_valid),
		.payload_data(payload_data),
		.payload_start(payload_start),
		.frame_err(frame_err)
	);

	fgp_rx #(
		.FGP_DATA_LEN_COLORS(FGP_DATA_LEN_COLORS)
	) fgp_rx_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.payload_valid(payload_valid),
		.payload_data(payload_data),
		.payload_start(payload_start),
		.frame_end(frame_end),
		.offset_valid(offset_valid),
		.offset_data(offset_data),
		.data_valid(data_valid),
		.data_byte(data_byte)
	);

	bytes_to_colors bytes_to_colors_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.data_valid(data_valid),
		.data_byte(data_byte),
		.frame_end(frame_end),
		.color_valid(color_valid),
		.color(color)
	);

	vram_stream_writer #(
		.FGP_DATA_LEN_COLORS(FGP_DATA_LEN_COLORS),
		.VRAM_ADDR_WIDTH(VRAM_ADDR_WIDTH)
	) vram_stream_writer_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.offset_valid(offset_valid),
		.offset_data(offset_data),
		.color_valid(color_valid),
		.color(color),
		.vram_we(vram_we),
		.vram_waddr(vram_waddr),
		.vram_wdata(vram_wdata)
	);

endmodule

//--- tb/eth_rx_vram_checker.sv
////////////////////
// Protocol assertions for the receive top level
////////////////////
`timescale 1ns/1ps

module eth_rx_vram_checker #(
	parameter int VRAM_ADDR_WIDTH = 14
) (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic offset_valid,
	input logic vram_we,
	input logic [VRAM_ADDR_WIDTH-1:0] vram_waddr,
	input logic frame_err
);

	// Failed assertions so far
	int fail_cnt = 0;
	// Address of the previous write of the current packet
	logic [VRAM_ADDR_WIDTH-1:0] last_addr;
	logic have_last;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst || offset_valid) begin
			have_last <= 1'b0;
		end else if (vram_we) begin
			have_last <= 1'b1;
			last_addr <= vram_waddr;
		end
	end

	// Nothing leaves the chain while it is held in reset
	reset_quiet: assert property (@(posedge clk)
		eth_rx_downstream_rst && $past(eth_rx_downstream_rst) |-> !vram_we && !frame_err)
	else begin
		fail_cnt++;
		$error("vram_we or frame_err high during reset");
	end

	frame_err_pulse: assert property (@(posedge clk) frame_err |=> !frame_err)
	else begin
		fail_cnt++;
		$error("frame_err held for more than one cycle");
	end

	// Writes of one packet go to consecutive addresses
	addr_step: assert property (@(posedge clk)
		vram_we && have_last |-> vram_waddr == VRAM_ADDR_WIDTH'(last_addr + 1'b1))
	else begin
		fail_cnt++;
		$error("vram_waddr did not advance by one within a packet");
	end

endmodule

//--- tb/eth_rx_vram_tb.sv
////////////////////
// Testbench for the RMII receive chain
// with a model of the expected video RAM writes
////////////////////
`timescale 1ns/1ps

module eth_rx_vram_tb;
	import eth_rx_pkg::*;

	localparam int FGP_DATA_LEN_COLORS = 8;
	localparam int VRAM_ADDR_WIDTH = 10;
	localparam int DATA_LEN_BYTES = FGP_DATA_LEN_COLORS * 3 / 2;
	// Ten times the 600-cycle bound of one test
	localparam int TIMEOUT_CYCLES = 10 * 600;

	logic clk = 1'b0;
	logic eth_rx_downstream_rst;
	logic crs_dv;
	logic [1:0] rxd;
	logic vram_we;
	logic [VRAM_ADDR_WIDTH-1:0] vram_waddr;
	color_t vram_wdata;
	logic frame_err;

	string test_name = "reset";
	logic [31:0] rng_state = 32'h1361874d;
	int cycle_cnt = 0;
	int err_seen = 0;
	int err_base = 0;
	// Expected writes as {address, color} with the oldest first
	logic [VRAM_ADDR_WIDTH+COLOR_LEN-1:0] exp_q[$];

	always #50 clk = ~clk;

	eth_rx_vram_top #(
		.FGP_DATA_LEN_COLORS(FGP_DATA_LEN_COLORS),
		.VRAM_ADDR_WIDTH(VRAM_ADDR_WIDTH)
	) dut_i (.*);

	bind eth_rx_vram_top eth_rx_vram_checker #(
		.VRAM_ADDR_WIDTH(VRAM_ADDR_WIDTH)
	) eth_rx_vram_checker_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.offset_valid(offset_valid),
		.vram_we(vram_we),
		.vram_waddr(vram_waddr),
		.frame_err(frame_err)
	);

	// Xorshift generator for offsets, MAC bytes and data
	function automatic logic [BYTE_LEN-1:0] next_rand_byte();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state[BYTE_LEN-1:0];
	endfunction

	// Packet k starts at color k times the colors per packet
	function automatic void queue_write(input logic [BYTE_LEN-1:0] offset, input int idx,
			input color_t c);
		exp_q.push_back({VRAM_ADDR_WIDTH'(int'(offset) * FGP_DATA_LEN_COLORS + idx), c});
	endfunction

	task automatic check_frame_err(input int exp_err);
		assert (err_seen - err_base == exp_err) else begin
			$display("[FAIL] %s: expected frame_err pulses %0d, actual %0d",
				test_name, exp_err, err_seen - err_base);
			$display("Errors found");
			$fatal(1);
		end
		err_base = err_seen;
	endtask

	// Sends four dibits with the least significant first
	task automatic send_byte(input logic [BYTE_LEN-1:0] b);
		for (int d = 0; d < 4; d++) begin
			@(posedge clk);
			crs_dv <= 1'b1;
			rxd <= b[2*d +: 2];
		end
	endtask

	task automatic send_frame(input logic [BYTE_LEN-1:0] sfd, input logic [15:0] ethertype,
			input int n_data, input int n_tail);
		logic [BYTE_LEN-1:0] offset;
		logic [BYTE_LEN-1:0] data_q[$];
		int n_used;
		int n_col;
		bit writes_expected;
		offset = next_rand_byte();
		for (int i = 0; i < n_data; i++) begin
			data_q.push_back(next_rand_byte());
		end
		writes_expected = (sfd == SFD_BYTE) && (ethertype == ETHERTYPE_FGP);
		// Only the data block is repacked into two colors per three bytes
		n_used = (n_data < DATA_LEN_BYTES) ? n_data : DATA_LEN_BYTES;
		n_col = 0;
		for (int i = 0; writes_expected && i + 1 < n_used; i += 3) begin
			queue_write(offset, n_col, {data_q[i], data_q[i+1][7:4]});
			n_col++;
			if (i + 2 < n_used) begin
				queue_write(offset, n_col, {data_q[i+1][3:0], data_q[i+2]});
				n_col++;
			end
		end
		repeat (MAX_PREAMBLE_LEN) send_byte(PREAMBLE_BYTE);
		send_byte(sfd);
		repeat (ETH_MAC_HDR_LEN) send_byte(next_rand_byte());
		send_byte(ethertype[15:8]);
		send_byte(ethertype[7:0]);
		send_byte(offset);
		foreach (data_q[i]) begin
			send_byte(data_q[i]);
		end
		repeat (n_tail) send_byte(next_rand_byte());
		@(posedge clk);
		crs_dv <= 1'b0;
		rxd <= 2'b00;
		// Idle gap while the queued writes drain
		repeat (16) @(posedge clk);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (12) @(posedge clk);
		check_frame_err((sfd == SFD_BYTE) ? 0 : 1);
	endtask

	// Outputs are sampled on the falling edge where they are stable
	always @(negedge clk) begin : output_monitor
		logic [VRAM_ADDR_WIDTH+COLOR_LEN-1:0] exp_w;
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$fatal(1);
		end
		if (dut_i.eth_rx_vram_checker_i.fail_cnt != 0) begin
			$display("Bound protocol assertion failed in test %s", test_name);
			$display("Errors found");
			$fatal(1);
		end
		if (frame_err) begin
			err_seen++;
		end
		if (vram_we) begin
			assert (exp_q.size() != 0) else begin
				$display("Unexpected video RAM write at address %0h in test %s",
					vram_waddr, test_name);
				$display("Errors found");
				$fatal(1);
			end
			exp_w = exp_q.pop_front();
			assert ({vram_waddr, vram_wdata} == exp_w) else begin
				$display("[FAIL] %s: expected addr %0h color %03h, actual addr %0h color %03h",
					test_name, exp_w[COLOR_LEN +: VRAM_ADDR_WIDTH], exp_w[COLOR_LEN-1:0],
					vram_waddr, vram_wdata);
				$display("Errors found");
				$fatal(1);
			end
		end
	end

	initial begin
		eth_rx_downstream_rst = 1'b1;
		crs_dv = 1'b0;
		rxd = 2'b00;
		repeat (10) @(posedge clk);
		eth_rx_downstream_rst <= 1'b0;

		test_name = "idle_after_reset";
		repeat (40) @(posedge clk);
		check_frame_err(0);

		test_name = "fgp_frame";
		send_frame(SFD_BYTE, ETHERTYPE_FGP, DATA_LEN_BYTES, 4);

		test_name = "other_ethertype";
		send_frame(SFD_BYTE, 16'h0800, DATA_LEN_BYTES, 4);

		test_name = "bad_delimiter";
		send_frame(8'hA7, ETHERTYPE_FGP, DATA_LEN_BYTES, 4);
		send_frame(SFD_BYTE, ETHERTYPE_FGP, DATA_LEN_BYTES, 4);

		test_name = "extra_bytes";
		send_frame(SFD_BYTE, ETHERTYPE_FGP, DATA_LEN_BYTES + 6, 4);

		// Frame cut after 7 data bytes and a full frame behind it
		test_name = "cut_frame";
		send_frame(SFD_BYTE, ETHERTYPE_FGP, 7, 0);
		send_frame(SFD_BYTE, ETHERTYPE_FGP, DATA_LEN_BYTES, 4);

		if (dut_i.eth_rx_vram_checker_i.fail_cnt == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Bound protocol assertions failed");
			$display("Errors found");
			$fatal(1);
		end
	end

endmodule

//--- verilog.f
hw/eth_rx_pkg.sv
hw/rmii_byte_assembler.sv
hw/eth_frame_parser.sv
hw/fgp_rx.sv
hw/bytes_to_colors.sv
hw/vram_stream_writer.sv
hw/eth_rx_vram_top.sv
tb/eth_rx_vram_checker.sv
tb/eth_rx_vram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive chain testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module eth_rx_vram_tb -f verilog.f
./obj_dir/Veth_rx_vram_tb | tee sim.log
if grep -q "^No errors$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
